//--- test/rv_core_trace.txt
# test NAME, then p WORD for each program word from address 0,
# then w ADDR BE DATA for each expected store in order, and end
test alu
p FFB00093 p 00300113 p 402081B3 p 0020A233 p 0020B2B3 p 4010D313 p 00411393 p 01C0D413
p 00700013 p 10302023 p 10402223 p 10502423 p 10602623 p 10702823 p 10802A23 p 10002C23
p 00000073
w 100 F FFFFFFF8 w 104 F 00000001 w 108 F 00000000 w 10C F FFFFFFFD
w 110 F 00000030 w 114 F 0000000F w 118 F 00000000
end
test branch_jump
p 00100093 p FFF00113 p 00114463 p 10202023 p 00116463 p 10102023 p 008001EF
p 10202223 p 10302223 p 03000267 p 10202423 p 10202423 p 10402423 p 00000073
w 100 F 00000001 w 104 F 0000001C w 108 F 00000028
end
test branch_eq_ge
p 00100093 p 00009463 p 10102023 p 00008463 p 10102023 p 00105463 p 00108093
p 0000F463 p 10002223 p 10102223 p 00000073
w 100 F 00000001 w 104 F 00000002
end
test byte_half_store
p 123450B7 p 67808093 p 10100023 p 101000A3 p 10100123 p 101001A3 p 10101223
p 10101323 p 00000073
w 100 1 00000078 w 100 2 00007800 w 100 4 00780000 w 100 8 78000000
w 104 3 00005678 w 104 C 56780000
end
test loads
p 02C02083 p 02D00103 p 02D04183 p 02E01203 p 02E05283 p 10102023 p 10202223
p 10302423 p 10402623 p 10502823 p 00000073 p 8081F2F3
w 100 F 8081F2F3 w 104 F FFFFFFF2 w 108 F 000000F2 w 10C F FFFF8081 w 110 F 00008081
end
test upper_imm
p ABCDE0B7 p 00001117 p 10102023 p 10202223 p 00000073
w 100 F ABCDE000 w 104 F 00001004
end

//--- vlog.f
+incdir+common
common/rv_pkg.sv
common/rv_ifs.sv
core/decoder.sv
core/fetch_unit.sv
core/exec_unit.sv
core/lsu.sv
design/mem_arbiter.sv
design/rv_core_top.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - common/rv_ifs.sv
      - core/decoder.sv
      - core/fetch_unit.sv
      - core/exec_unit.sv
      - core/lsu.sv
      - design/mem_arbiter.sv
      - design/rv_core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/rv_core_sva.sv
      - test/tb_rv_core.sv

//--- test/tb_rv_core.sv
`default_nettype none
`include "rv_config.svh"

module tb_rv_core;

  localparam int MEM_WORDS = 2 ** `RV_MEM_AW;

  logic        clk;
  logic        rst;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [3:0]  mem_be;
  logic [31:0] mem_wdata;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic        halt;

  logic [31:0] mem [0:MEM_WORDS-1];

  // trace contents, flattened over all tests
  string       names[$];
  int          prog_start[$];
  int          prog_len[$];
  int          exp_start[$];
  int          exp_len[$];
  logic [31:0] prog_w[$];
  logic [31:0] exp_addr[$];
  logic [3:0]  exp_be[$];
  logic [31:0] exp_data[$];

  // write handshakes seen in the current test
  logic [31:0] wr_addr[$];
  logic [3:0]  wr_be[$];
  logic [31:0] wr_data[$];

  int cycles;
  int limit;
  int test_errs;
  int n_pass;
  int n_fail;
  int trace_ok;

  rv_core_top u_rv_core_top (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_be    (mem_be),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .halt      (halt)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: no finish within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic read_trace(output int ok);
    int          fd;
    int          rc;
    string       tok;
    string       line;
    logic [31:0] a;
    logic [3:0]  b;
    logic [31:0] d;
    ok = 0;
    fd = $fopen("test/rv_core_trace.txt", "r");
    if (fd != 0) begin
      ok = 1;
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          rc = $fgets(line, fd);
        end else if (tok == "test") begin
          rc = $fscanf(fd, "%s", line);
          if (rc != 1) ok = 0;
          names.push_back(line);
          prog_start.push_back(prog_w.size());
          prog_len.push_back(0);
          exp_start.push_back(exp_addr.size());
          exp_len.push_back(0);
        end else if (tok == "p") begin
          rc = $fscanf(fd, "%h", d);
          if (rc != 1) ok = 0;
          prog_w.push_back(d);
          prog_len[prog_len.size()-1]++;
        end else if (tok == "w") begin
          rc = $fscanf(fd, "%h %h %h", a, b, d);
          if (rc != 3) ok = 0;
          exp_addr.push_back(a);
          exp_be.push_back(b);
          exp_data.push_back(d);
          exp_len[exp_len.size()-1]++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hC0DE0000 ^ (i << 2);
    end
    for (int j = 0; j < prog_len[t]; j++) begin
      mem[j] = prog_w[prog_start[t] + j];
    end
  endtask

  // memory responder, everything sampled and driven 1 unit after the edge
  initial begin
    int unsigned delay;
    int          idx;
    forever begin
      @(posedge clk);
      #1;
      if (!rst && mem_req && !mem_ack) begin
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        #1;
        idx = mem_addr[`RV_MEM_AW+1:2];
        if (mem_we) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_be[k]) mem[idx][8*k +: 8] = mem_wdata[8*k +: 8];
          end
          wr_addr.push_back(mem_addr);
          wr_be.push_back(mem_be);
          wr_data.push_back(mem_wdata);
        end
        mem_rdata = mem[idx];
        mem_ack   = 1'b1;
        do begin
          @(posedge clk);
          #1;
        end while (mem_req);
        mem_ack = 1'b0;
      end
    end
  end

  task automatic run_test(input int t);
    int n;
    int e;
    int quiet_ok;
    int halt_ok;
    test_errs = 0;
    @(posedge clk);
    #1;
    rst = 1'b1;
    load_program(t);
    wr_addr.delete();
    wr_be.delete();
    wr_data.delete();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (!halt) else begin
      $display("test %s: halt still high after reset", names[t]);
      test_errs++;
    end
    while (!mem_req) begin
      @(posedge clk);
      #1;
    end
    assert (mem_addr == `RV_RESET_PC && !mem_we) else begin
      $display("test %s: first fetch after reset not at address 0", names[t]);
      test_errs++;
    end
    while (!halt) begin
      @(posedge clk);
      #1;
    end
    quiet_ok = 1;
    halt_ok  = 1;
    repeat (20) begin
      @(posedge clk);
      #1;
      if (mem_req) quiet_ok = 0;
      if (!halt) halt_ok = 0;
    end
    assert (quiet_ok) else begin
      $display("test %s: memory request raised after halt", names[t]);
      test_errs++;
    end
    assert (halt_ok) else begin
      $display("test %s: halt dropped before reset", names[t]);
      test_errs++;
    end
    n = (wr_addr.size() < exp_len[t]) ? wr_addr.size() : exp_len[t];
    for (int i = 0; i < n; i++) begin
      e = exp_start[t] + i;
      assert (wr_addr[i] == exp_addr[e] && wr_be[i] == exp_be[e] && wr_data[i] == exp_data[e])
      else begin
        $display("mismatch %s store %0d: expected %h/%h/%h actual %h/%h/%h", names[t], i,
                 exp_addr[e], exp_be[e], exp_data[e], wr_addr[i], wr_be[i], wr_data[i]);
        test_errs++;
      end
    end
    assert (wr_addr.size() == exp_len[t]) else begin
      $display("test %s: expected %0d stores but saw %0d", names[t], exp_len[t], wr_addr.size());
      test_errs++;
    end
    if (test_errs == 0) begin
      $display("test %s: pass", names[t]);
      n_pass++;
    end else begin
      $display("test %s: fail with %0d errors", names[t], test_errs);
      n_fail++;
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    cycles    = 0;
    limit     = 0;
    n_pass    = 0;
    n_fail    = 0;
    void'($urandom(77));
    read_trace(trace_ok);
    if (!trace_ok || names.size() == 0) begin
      $display("trace file missing, empty or malformed");
      $display("Result: FAILED");
      $finish;
    end else begin
      limit = 40 * prog_w.size() + 100 * names.size();
      for (int t = 0; t < names.size(); t++) begin
        run_test(t);
      end
      $display("tests run %0d, passed %0d, failed %0d", names.size(), n_pass, n_fail);
      if (n_fail == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- test/rv_core_sva.sv
`default_nettype none
`include "rv_config.svh"

module rv_core_sva (
  input logic                clk,
  input logic                rst,
  input logic                fetch_ack,
  input logic                data_ack,
  input logic                mem_req,
  input logic                mem_ack,
  input logic                mem_we,
  input logic [`RV_XLEN-1:0] mem_addr,
  input logic [3:0]          mem_be,
  input logic [`RV_XLEN-1:0] mem_wdata
);

  // req held until the responder answers
  assert property (@(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req)
    else $error("memory req dropped before ack");

  assert property (@(posedge clk) disable iff (rst) $rose(mem_ack) |-> mem_req)
    else $error("memory ack rose without req");

  // request fields frozen for the whole handshake
  assert property (@(posedge clk) disable iff (rst)
    $past(mem_req) && mem_req |-> $stable({mem_addr, mem_we, mem_be, mem_wdata}))
    else $error("memory request fields changed while req was high");

  // the grant cannot move while an ack is still being routed
  assert property (@(posedge clk) disable iff (rst)
    !(fetch_ack && data_ack) && !($past(fetch_ack) && data_ack)
    && !($past(data_ack) && fetch_ack))
    else $error("fetch and data ack high together or back to back");

endmodule

bind mem_arbiter rv_core_sva u_rv_core_sva (
  .clk       (clk),
  .rst       (rst),
  .fetch_ack (fetch.ack),
  .data_ack  (data.ack),
  .mem_req   (mem_req),
  .mem_ack   (mem_ack),
  .mem_we    (mem_we),
  .mem_addr  (mem_addr),
  .mem_be    (mem_be),
  .mem_wdata (mem_wdata)
);

`default_nettype wire

//--- design/rv_core_top.sv
`default_nettype none
`include "rv_config.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                rst,
  output logic                mem_req,
  output logic                mem_we,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [3:0]          mem_be,
  output logic [`RV_XLEN-1:0] mem_wdata,
  input  logic                mem_ack,
  input  logic [`RV_XLEN-1:0] mem_rdata,
  output logic                halt
);

  mem_if   fetch_mem ();
  mem_if   data_mem ();
  issue_if issue ();
  lsu_if   ls ();

  fetch_unit u_fetch_unit (
    .clk   (clk),
    .rst   (rst),
    .halt  (halt),
    .mem   (fetch_mem.requester),
    .issue (issue.fetch)
  );

  exec_unit u_exec_unit (
    .clk   (clk),
    .rst   (rst),
    .issue (issue.exec),
    .ls    (ls.requester),
    .halt  (halt)
  );

  lsu u_lsu (
    .clk (clk),
    .rst (rst),
    .ls  (ls.responder),
    .mem (data_mem.requester)
  );

  // single external port shared by fetch and lsu
  mem_arbiter u_mem_arbiter (
    .clk       (clk),
    .rst       (rst),
    .fetch     (fetch_mem.arbiter),
    .data      (data_mem.arbiter),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_be    (mem_be),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`default_nettype none
`include "rv_config.svh"

module mem_arbiter (
  input  logic                clk,
  input  logic                rst,
  mem_if.arbiter              fetch,
  mem_if.arbiter              data,
  output logic                mem_req,
  output logic                mem_we,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [3:0]          mem_be,
  output logic [`RV_XLEN-1:0] mem_wdata,
  input  logic                mem_ack,
  input  logic [`RV_XLEN-1:0] mem_rdata
);

  logic grant_data_q;
  logic locked_q;
  logic seen_ack_q;

  // lsu wins a tie, grant held until ack falls
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_data_q <= 1'b0;
      locked_q     <= 1'b0;
      seen_ack_q   <= 1'b0;
    end else if (!locked_q) begin
      if (data.req || fetch.req) begin
        grant_data_q <= data.req;
        locked_q     <= 1'b1;
      end
    end else if (mem_ack) begin
      seen_ack_q <= 1'b1;
    end else if (seen_ack_q) begin
      seen_ack_q <= 1'b0;
      locked_q   <= 1'b0;
    end
  end

  assign mem_req   = locked_q && (grant_data_q ? data.req : fetch.req);
  assign mem_we    = grant_data_q ? data.we : fetch.we;
  assign mem_addr  = grant_data_q ? data.addr : fetch.addr;
  assign mem_be    = grant_data_q ? data.be : fetch.be;
  assign mem_wdata = grant_data_q ? data.wdata : fetch.wdata;

  assign fetch.ack   = locked_q && !grant_data_q && mem_ack;
  assign data.ack    = locked_q && grant_data_q && mem_ack;
  assign fetch.rdata = grant_data_q ? '0 : mem_rdata;
  assign data.rdata  = grant_data_q ? mem_rdata : '0;

endmodule

`default_nettype wire

//--- core/lsu.sv
`default_nettype none
`include "rv_config.svh"

module lsu (
  input  logic     clk,
  input  logic     rst,
  lsu_if.responder ls,
  mem_if.requester mem
);
  import rv_pkg::*;

  logic [1:0]          off;
  logic [`RV_XLEN-1:0] word_q;
  logic [`RV_XLEN-1:0] shifted;
  logic                mem_req_q;
  logic                wait_low_q;
  logic                ls_ack_q;

  assign off = ls.addr[1:0];

  // memory handshake nested inside the lsu_if handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_q  <= 1'b0;
      wait_low_q <= 1'b0;
      ls_ack_q   <= 1'b0;
    end else if (mem_req_q) begin
      if (mem.ack) begin
        mem_req_q  <= 1'b0;
        wait_low_q <= 1'b1;
      end
    end else if (wait_low_q) begin
      if (!mem.ack) begin
        wait_low_q <= 1'b0;
        ls_ack_q   <= 1'b1;
      end
    end else if (ls_ack_q) begin
      if (!ls.req) begin
        ls_ack_q <= 1'b0;
      end
    end else if (ls.req && !mem.ack) begin
      mem_req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req_q && mem.ack) begin
      word_q <= mem.rdata;
    end
  end

  // lanes follow the low address bits, misaligned halves get no lanes
  always_comb begin
    mem.be    = 4'b0000;
    mem.wdata = '0;
    case (ls.size)
      SIZE_BYTE: begin
        mem.be    = 4'b0001 << off;
        mem.wdata = {24'b0, ls.store_data[7:0]} << {off, 3'b000};
      end
      SIZE_HALF: begin
        if (!off[0]) begin
          mem.be    = off[1] ? 4'b1100 : 4'b0011;
          mem.wdata = {16'b0, ls.store_data[15:0]} << {off, 3'b000};
        end
      end
      SIZE_WORD: begin
        mem.be    = 4'b1111;
        mem.wdata = ls.store_data;
      end
      default: begin
      end
    endcase
  end

  assign shifted = word_q >> {off, 3'b000};

  always_comb begin
    ls.load_data = '0;
    case (ls.size)
      SIZE_BYTE: ls.load_data = {{24{shifted[7] & ~ls.unsigned_load}}, shifted[7:0]};
      SIZE_HALF: begin
        if (!off[0]) begin
          ls.load_data = {{16{shifted[15] & ~ls.unsigned_load}}, shifted[15:0]};
        end
      end
      SIZE_WORD: ls.load_data = word_q;
      default: ls.load_data = '0;
    endcase
  end

  assign mem.req  = mem_req_q;
  assign mem.addr = {ls.addr[`RV_XLEN-1:2], 2'b00};
  assign mem.we   = ls.we;
  assign ls.ack   = ls_ack_q;

endmodule

`default_nettype wire

//--- core/exec_unit.sv
`default_nettype none
`include "rv_config.svh"

module exec_unit (
  input  logic     clk,
  input  logic     rst,
  issue_if.exec    issue,
  lsu_if.requester ls,
  output logic     halt
);
  import rv_pkg::*;

  dec_t                dec;
  exec_state_e         state;
  logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] wb_data;
  logic [`RV_XLEN-1:0] load_q;
  logic                take;
  logic                mem_op;
  logic                retire;
  logic                ls_req_q;
  logic                halt_q;

  decoder u_decoder (
    .instr (issue.instr),
    .dec   (dec)
  );

  // x0 always reads as zero
  assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];
  assign op_b    = dec.use_imm ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_res = rs1_val + op_b;
      ALU_SUB:  alu_res = rs1_val - op_b;
      ALU_SLL:  alu_res = rs1_val << op_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'b0, rs1_val < op_b};
      ALU_XOR:  alu_res = rs1_val ^ op_b;
      ALU_SRL:  alu_res = rs1_val >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(rs1_val) >>> op_b[4:0];
      ALU_OR:   alu_res = rs1_val | op_b;
      default:  alu_res = rs1_val & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  take = (rs1_val == rs2_val);
      3'b001:  take = (rs1_val != rs2_val);
      3'b100:  take = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  take = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  take = (rs1_val < rs2_val);
      3'b111:  take = (rs1_val >= rs2_val);
      default: take = 1'b0;
    endcase
  end

  assign pc_plus4 = issue.pc + 32'd4;

  always_comb begin
    issue.next_pc = pc_plus4;
    if (dec.is_jal || (dec.is_branch && take)) begin
      issue.next_pc = issue.pc + dec.imm;
    end else if (dec.is_jalr) begin
      issue.next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
    end
  end

  always_comb begin
    if (dec.is_load) begin
      wb_data = load_q;
    end else if (dec.is_jal || dec.is_jalr) begin
      wb_data = pc_plus4;
    end else if (dec.opcode == OP_LUI) begin
      wb_data = dec.imm;
    end else if (dec.opcode == OP_AUIPC) begin
      wb_data = issue.pc + dec.imm;
    end else begin
      wb_data = alu_res;
    end
  end

  assign mem_op = dec.is_load || dec.is_store;
  // non-memory ops retire in RUN, loads and stores after the lsu handshake
  assign retire = (state == EX_RUN && !mem_op) || (state == EX_RETIRE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= EX_IDLE;
      ls_req_q <= 1'b0;
      halt_q   <= 1'b0;
    end else begin
      case (state)
        EX_IDLE: begin
          if (issue.valid) begin
            state <= EX_RUN;
          end
        end
        EX_RUN: begin
          if (mem_op) begin
            ls_req_q <= 1'b1;
            state    <= EX_MEM;
          end else if (dec.is_ecall) begin
            halt_q <= 1'b1;
            state  <= EX_HALTED;
          end else begin
            state <= EX_IDLE;
          end
        end
        EX_MEM: begin
          if (ls_req_q) begin
            if (ls.ack) begin
              ls_req_q <= 1'b0;
            end
          end else if (!ls.ack) begin
            state <= EX_RETIRE;
          end
        end
        EX_RETIRE: state <= EX_IDLE;
        // parked until reset
        default: state <= EX_HALTED;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == EX_MEM && ls_req_q && ls.ack) begin
      load_q <= ls.load_data;
    end
    if (retire && dec.writes_rd && dec.rd != 5'd0) begin
      regs[dec.rd] <= wb_data;
    end
  end

  assign ls.req           = ls_req_q;
  assign ls.addr          = alu_res;
  assign ls.we            = dec.is_store;
  assign ls.size          = dec.size;
  assign ls.unsigned_load = dec.load_unsigned;
  assign ls.store_data    = rs2_val;

  assign issue.done = retire;
  assign halt       = halt_q;

endmodule

`default_nettype wire

//--- core/fetch_unit.sv
`default_nettype none
`include "rv_config.svh"

module fetch_unit (
  input  logic     clk,
  input  logic     rst,
  input  logic     halt,
  mem_if.requester mem,
  issue_if.fetch   issue
);
  import rv_pkg::*;

  fetch_state_e        state;
  logic                req_q;
  logic                valid_q;
  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] instr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= FE_REQ;
      req_q   <= 1'b0;
      valid_q <= 1'b0;
      pc_q    <= `RV_RESET_PC;
    end else begin
      case (state)
        FE_REQ: begin
          // wait for the previous ack to clear before a new req
          if (!req_q) begin
            if (!halt && !mem.ack) begin
              req_q <= 1'b1;
            end
          end else if (mem.ack) begin
            req_q <= 1'b0;
            state <= FE_WAIT_ACK_LOW;
          end
        end
        FE_WAIT_ACK_LOW: begin
          if (!mem.ack) begin
            valid_q <= 1'b1;
            state   <= FE_HOLD;
          end
        end
        FE_HOLD: begin
          if (issue.done) begin
            valid_q <= 1'b0;
            pc_q    <= issue.next_pc;
            state   <= FE_REQ;
          end
        end
        default: state <= FE_REQ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FE_REQ && req_q && mem.ack) begin
      instr_q <= mem.rdata;
    end
  end

  // fetch is a full-word read
  assign mem.req   = req_q;
  assign mem.addr  = pc_q;
  assign mem.we    = 1'b0;
  assign mem.be    = 4'b1111;
  assign mem.wdata = '0;

  assign issue.valid = valid_q;
  assign issue.instr = instr_q;
  assign issue.pc    = pc_q;

endmodule

`default_nettype wire

//--- core/decoder.sv
`default_nettype none
`include "rv_config.svh"

module decoder (
  input  logic [`RV_XLEN-1:0] instr,
  output rv_pkg::dec_t        dec
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic                f7_zero;
  logic                f7_alt;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign f3      = instr[14:12];
  assign f7      = instr[31:25];
  assign f7_zero = (f7 == 7'b0000000);
  assign f7_alt  = (f7 == 7'b0100000);

  // funct3 to ALU op, alt picks sub or sra
  function automatic alu_op_e alu_sel(input logic [2:0] fn, input logic alt);
    case (fn)
      3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec               = '0;
    dec.opcode        = opcode_e'(instr[6:0]);
    dec.rd            = instr[11:7];
    dec.rs1           = instr[19:15];
    dec.rs2           = instr[24:20];
    dec.funct3        = f3;
    dec.imm           = imm_i;
    dec.alu_op        = ALU_ADD;
    dec.size          = acc_size_e'(f3[1:0]);
    dec.load_unsigned = f3[2];
    case (dec.opcode)
      OP_LUI, OP_AUIPC: begin
        dec.imm       = imm_u;
        dec.writes_rd = 1'b1;
      end
      OP_JAL: begin
        dec.imm       = imm_j;
        dec.writes_rd = 1'b1;
        dec.is_jal    = 1'b1;
      end
      OP_JALR: begin
        dec.use_imm   = 1'b1;
        dec.writes_rd = (f3 == 3'b000);
        dec.is_jalr   = (f3 == 3'b000);
      end
      OP_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = (f3[2:1] != 2'b01);
      end
      OP_LOAD: begin
        dec.use_imm   = 1'b1;
        dec.is_load   = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
        dec.writes_rd = dec.is_load;
      end
      OP_STORE: begin
        dec.imm       = imm_s;
        dec.use_imm   = 1'b1;
        dec.is_store  = (f3[2] == 1'b0) && (f3[1:0] != 2'b11);
      end
      OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_sel(f3, (f3 == 3'b101) && f7_alt);
        // shift-immediates carry their own funct7
        if (f3 == 3'b001) begin
          dec.writes_rd = f7_zero;
        end else if (f3 == 3'b101) begin
          dec.writes_rd = f7_zero || f7_alt;
        end else begin
          dec.writes_rd = 1'b1;
        end
      end
      OP_OP: begin
        dec.alu_op    = alu_sel(f3, f7_alt);
        dec.writes_rd = f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101));
      end
      OP_SYSTEM: begin
        dec.is_ecall = (instr[31:7] == 25'd0);
      end
      // fence and unknown opcodes retire with no effect
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- common/rv_ifs.sv
`default_nettype none
`include "rv_config.svh"

// four-phase memory port, one per requester
interface mem_if;
  logic                req;
  logic                ack;
  logic [`RV_XLEN-1:0] addr;
  logic                we;
  logic [3:0]          be;
  logic [`RV_XLEN-1:0] wdata;
  logic [`RV_XLEN-1:0] rdata;
  modport requester (output req, addr, we, be, wdata, input ack, rdata);
  modport arbiter (input req, addr, we, be, wdata, output ack, rdata);
endinterface

interface issue_if;
  logic                valid;
  logic [`RV_XLEN-1:0] instr;
  logic [`RV_XLEN-1:0] pc;
  logic                done;
  logic [`RV_XLEN-1:0] next_pc;
  modport fetch (output valid, instr, pc, input done, next_pc);
  modport exec (input valid, instr, pc, output done, next_pc);
endinterface

interface lsu_if;
  import rv_pkg::*;
  logic                req;
  logic                ack;
  logic [`RV_XLEN-1:0] addr;
  logic                we;
  acc_size_e           size;
  logic                unsigned_load;
  logic [`RV_XLEN-1:0] store_data;
  logic [`RV_XLEN-1:0] load_data;
  modport requester (output req, addr, we, size, unsigned_load, store_data,
                     input ack, load_data);
  modport responder (input req, addr, we, size, unsigned_load, store_data,
                     output ack, load_data);
endinterface

`default_nettype wire

//--- common/rv_pkg.sv
`default_nettype none
`include "rv_config.svh"

package rv_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_IMM      = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_OP       = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } acc_size_e;

  typedef enum logic [2:0] {
    EX_IDLE, EX_RUN, EX_MEM, EX_RETIRE, EX_HALTED
  } exec_state_e;

  typedef enum logic [1:0] {
    FE_REQ, FE_WAIT_ACK_LOW, FE_HOLD
  } fetch_state_e;

  typedef struct packed {
    opcode_e             opcode;
    alu_op_e             alu_op;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm;
    logic                use_imm;
    logic                writes_rd;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    logic                is_ecall;
    acc_size_e           size;
    logic                load_unsigned;
  } dec_t;

endpackage

`default_nettype wire

//--- common/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NREGS 32

// address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// word address bits decoded by the external memory
`define RV_MEM_AW 10

`endif
